// ==== rtl/buffers.sv ====
`timescale 1ns/1ps

module buffers #(
    parameter int NUM_BUFFERS = 2,
    parameter int DEPTH = 4
) (
    input  logic                           CLK,
    input  logic                           nRST,
    input  logic                           in_valid,
    input  logic [$clog2(NUM_BUFFERS)-1:0] in_vc,
    input  noc_pkg::flit_t                 in_flit,
    output logic [NUM_BUFFERS-1:0]         buf_full,
    buffers_if.buffs                       buf_if
);
    localparam int CW = $clog2(DEPTH + 1);
    localparam int LW = noc_pkg::PKT_LENGTH_WIDTH;

    noc_pkg::buf_state_t [NUM_BUFFERS-1:0] state;
    noc_pkg::port_t [NUM_BUFFERS-1:0]      outport_q;
    logic [NUM_BUFFERS-1:0]                vc_q;
    logic [NUM_BUFFERS-1:0]                wen;
    logic [NUM_BUFFERS-1:0]                load_en;
    logic [NUM_BUFFERS-1:0]                done;
    logic [NUM_BUFFERS-1:0][CW-1:0]        count;
    logic [NUM_BUFFERS-1:0][LW-1:0]        load_val;

    for (genvar i = 0; i < NUM_BUFFERS; i++) begin : g_buf
        flit_fifo #(
            .DEPTH(DEPTH)
        ) u_fifo (
            .CLK   (CLK),
            .nRST  (nRST),
            .WEN   (wen[i]),
            .REN   (buf_if.REN[i]),
            .wdata (in_flit),
            .rdata (buf_if.rdata[i]),
            .empty (buf_if.empty[i]),
            .full  (buf_full[i]),
            .count (count[i])
        );

        flit_counter u_counter (
            .CLK          (CLK),
            .nRST         (nRST),
            .count_enable (buf_if.REN[i]),
            .load_en      (load_en[i]),
            .load_val     (load_val[i]),
            .done         (done[i])
        );

        // a new packet must open with its head flit.
        assert property (@(posedge CLK) disable iff (!nRST)
            (wen[i] && state[i] == noc_pkg::IDLE && buf_if.empty[i]) |-> in_flit.head)
            else $error("buffers: packet on buffer %0d starts without a head", i);
    end

    always_comb begin
        for (int i = 0; i < NUM_BUFFERS; i++) begin
            wen[i]     = in_valid && (int'(in_vc) == i);
            load_en[i] = (state[i] == noc_pkg::IDLE) && (wen[i] || count[i] != '0);
            // a queued head takes priority over the one being written.
            if (count[i] != '0) begin
                load_val[i] = noc_pkg::expected_num_flits(buf_if.rdata[i].payload);
            end else begin
                load_val[i] = noc_pkg::expected_num_flits(in_flit.payload);
            end
            buf_if.req_routing[i] = (state[i] == noc_pkg::ROUTING);
            buf_if.req_vc[i]      = (state[i] == noc_pkg::VC_ALLOCATION);
            buf_if.req_switch[i]  = (state[i] == noc_pkg::ACTIVE) && !done[i];
        end
        buf_if.outport_sel = outport_q;
        buf_if.vc_sel      = vc_q;
        buf_if.pkt_release = done;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_BUFFERS; i++) begin
                state[i]     <= noc_pkg::IDLE;
                outport_q[i] <= noc_pkg::PORT_LOCAL;
                vc_q[i]      <= 1'b0;
            end
        end else begin
            for (int i = 0; i < NUM_BUFFERS; i++) begin
                case (state[i])
                    noc_pkg::IDLE: begin
                        if (load_en[i]) begin
                            state[i] <= noc_pkg::ROUTING;
                        end
                    end
                    noc_pkg::ROUTING: begin
                        if (buf_if.routing_granted[i]) begin
                            outport_q[i] <= buf_if.routing_outport;
                            state[i]     <= noc_pkg::VC_ALLOCATION;
                        end
                    end
                    noc_pkg::VC_ALLOCATION: begin
                        if (buf_if.vc_granted[i]) begin
                            vc_q[i]  <= buf_if.vc_selection;
                            state[i] <= noc_pkg::ACTIVE;
                        end
                    end
                    default: begin
                        if (done[i]) begin
                            state[i] <= noc_pkg::IDLE;
                        end
                    end
                endcase
            end
        end
    end

endmodule

// ==== rtl/buffers_if.sv ====
`timescale 1ns/1ps

interface buffers_if #(
    parameter int NUM_BUFFERS = 2
);
    logic [NUM_BUFFERS-1:0]             req_routing;
    logic [NUM_BUFFERS-1:0]             req_vc;
    logic [NUM_BUFFERS-1:0]             req_switch;
    noc_pkg::port_t [NUM_BUFFERS-1:0]   outport_sel;
    logic [NUM_BUFFERS-1:0]             vc_sel;
    logic [NUM_BUFFERS-1:0]             empty;
    logic [NUM_BUFFERS-1:0]             pkt_release;
    noc_pkg::flit_t [NUM_BUFFERS-1:0]   rdata;

    logic [NUM_BUFFERS-1:0]             routing_granted;
    noc_pkg::port_t                     routing_outport;
    logic [NUM_BUFFERS-1:0]             vc_granted;
    logic                               vc_selection;
    logic [NUM_BUFFERS-1:0]             REN;

    modport buffs (
        output req_routing, req_vc, req_switch, outport_sel, vc_sel,
        output empty, pkt_release, rdata,
        input  routing_granted, routing_outport, vc_granted, vc_selection, REN
    );

    modport route (
        input  req_routing, rdata,
        output routing_granted, routing_outport
    );

    modport vcalloc (
        input  req_vc, outport_sel, vc_sel, pkt_release,
        output vc_granted, vc_selection
    );

    modport switch (
        input  req_switch, empty, outport_sel, vc_sel, rdata,
        output REN
    );

endinterface

// ==== rtl/flit_counter.sv ====
`timescale 1ns/1ps

module flit_counter (
    input  logic                                  CLK,
    input  logic                                  nRST,
    input  logic                                  count_enable,
    input  logic                                  load_en,
    input  logic [noc_pkg::PKT_LENGTH_WIDTH-1:0]  load_val,
    output logic                                  done
);
    logic [noc_pkg::PKT_LENGTH_WIDTH-1:0] limit;
    logic [noc_pkg::PKT_LENGTH_WIDTH-1:0] count;
    logic [noc_pkg::PKT_LENGTH_WIDTH-1:0] count_next;

    assign count_next = count + 1'b1;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            limit <= '0;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (load_en) begin
                limit <= load_val;
                count <= '0;
            end else if (count_enable) begin
                // the read of the last flit closes the packet.
                if (count_next == limit) begin
                    count <= '0;
                    done  <= 1'b1;
                end else begin
                    count <= count_next;
                end
            end
        end
    end

endmodule

// ==== rtl/flit_fifo.sv ====
`timescale 1ns/1ps

module flit_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       WEN,
    input  logic                       REN,
    input  noc_pkg::flit_t             wdata,
    output noc_pkg::flit_t             rdata,
    output logic                       empty,
    output logic                       full,
    output logic [$clog2(DEPTH+1)-1:0] count
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    noc_pkg::flit_t mem [DEPTH];
    logic [AW-1:0]  wptr;
    logic [AW-1:0]  rptr;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        if (ptr == AW'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge CLK) begin
        if (WEN) begin
            mem[wptr] <= wdata;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (WEN) begin
                wptr <= next_ptr(wptr);
            end
            if (REN) begin
                rptr <= next_ptr(rptr);
            end
            case ({WEN, REN})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the oldest entry is always visible.
    assign rdata = mem[rptr];
    assign empty = (count == '0);
    assign full  = (count == CW'(DEPTH));

    assert property (@(posedge CLK) disable iff (!nRST) WEN |-> !full)
        else $error("flit_fifo: write to a full FIFO");

    assert property (@(posedge CLK) disable iff (!nRST) REN |-> !empty)
        else $error("flit_fifo: read from an empty FIFO");

endmodule

// ==== rtl/noc_pkg.sv ====
package noc_pkg;

    localparam int NUM_OUTPORTS = 5;
    localparam int PKT_LENGTH_WIDTH = 8;

    typedef enum logic [2:0] {
        PORT_LOCAL = 3'd0,
        PORT_EAST  = 3'd1,
        PORT_WEST  = 3'd2,
        PORT_NORTH = 3'd3,
        PORT_SOUTH = 3'd4
    } port_t;

    typedef struct packed {
        logic [3:0]                  dest_x;
        logic [3:0]                  dest_y;
        logic [PKT_LENGTH_WIDTH-1:0] length;
        logic [15:0]                 tag;
    } head_fields_t;

    // the first flit of a packet reads its payload as a head, all later flits as data.
    typedef union packed {
        head_fields_t head;
        logic [31:0]  data;
    } flit_payload_u;

    typedef struct packed {
        logic          head;
        flit_payload_u payload;
    } flit_t;

    typedef enum logic [1:0] {
        IDLE,
        ROUTING,
        VC_ALLOCATION,
        ACTIVE
    } buf_state_t;

    // a length of zero still describes a packet of one flit.
    function automatic logic [PKT_LENGTH_WIDTH-1:0] expected_num_flits(
        input flit_payload_u payload
    );
        if (payload.head.length == '0) begin
            return PKT_LENGTH_WIDTH'(1);
        end
        return payload.head.length;
    endfunction

endpackage

// ==== rtl/route_compute.sv ====
`timescale 1ns/1ps

module route_compute #(
    parameter int NUM_BUFFERS = 2,
    parameter int ROUTER_X = 1,
    parameter int ROUTER_Y = 1
) (
    input logic      CLK,
    input logic      nRST,
    buffers_if.route buf_if
);
    localparam int IW = $clog2(NUM_BUFFERS);

    logic [IW-1:0] rr_ptr;
    logic [IW-1:0] sel;
    logic          found;

    always_comb begin
        int idx;
        found = 1'b0;
        sel   = rr_ptr;
        for (int k = 0; k < NUM_BUFFERS; k++) begin
            idx = (int'(rr_ptr) + k) % NUM_BUFFERS;
            if (!found && buf_if.req_routing[idx]) begin
                found = 1'b1;
                sel   = IW'(idx);
            end
        end
    end

    // XY order resolves x before it looks at y.
    always_comb begin
        noc_pkg::head_fields_t hdr;
        hdr = buf_if.rdata[sel].payload.head;
        buf_if.routing_granted      = '0;
        buf_if.routing_granted[sel] = found;
        if (hdr.dest_x != 4'(ROUTER_X)) begin
            if (hdr.dest_x > 4'(ROUTER_X)) begin
                buf_if.routing_outport = noc_pkg::PORT_EAST;
            end else begin
                buf_if.routing_outport = noc_pkg::PORT_WEST;
            end
        end else if (hdr.dest_y != 4'(ROUTER_Y)) begin
            if (hdr.dest_y > 4'(ROUTER_Y)) begin
                buf_if.routing_outport = noc_pkg::PORT_NORTH;
            end else begin
                buf_if.routing_outport = noc_pkg::PORT_SOUTH;
            end
        end else begin
            buf_if.routing_outport = noc_pkg::PORT_LOCAL;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rr_ptr <= '0;
        end else if (found) begin
            rr_ptr <= (sel == IW'(NUM_BUFFERS - 1)) ? '0 : sel + 1'b1;
        end
    end

endmodule

// ==== rtl/router_input_port.sv ====
`timescale 1ns/1ps

module router_input_port #(
    parameter int NUM_BUFFERS = 2,
    parameter int DEPTH = 4,
    parameter int ROUTER_X = 1,
    parameter int ROUTER_Y = 1
) (
    input  logic                              CLK,
    input  logic                              nRST,
    input  logic                              in_valid,
    input  logic [$clog2(NUM_BUFFERS)-1:0]    in_vc,
    input  noc_pkg::flit_t                    in_flit,
    output logic [NUM_BUFFERS-1:0]            buf_full,
    input  logic [noc_pkg::NUM_OUTPORTS-1:0]  out_ready,
    output logic [noc_pkg::NUM_OUTPORTS-1:0]  out_valid,
    output logic                              out_vc,
    output noc_pkg::flit_t                    out_flit
);
    buffers_if #(.NUM_BUFFERS(NUM_BUFFERS)) buf_if ();

    buffers #(
        .NUM_BUFFERS (NUM_BUFFERS),
        .DEPTH       (DEPTH)
    ) u_buffers (
        .CLK      (CLK),
        .nRST     (nRST),
        .in_valid (in_valid),
        .in_vc    (in_vc),
        .in_flit  (in_flit),
        .buf_full (buf_full),
        .buf_if   (buf_if.buffs)
    );

    route_compute #(
        .NUM_BUFFERS (NUM_BUFFERS),
        .ROUTER_X    (ROUTER_X),
        .ROUTER_Y    (ROUTER_Y)
    ) u_route_compute (
        .CLK    (CLK),
        .nRST   (nRST),
        .buf_if (buf_if.route)
    );

    vc_allocator #(
        .NUM_BUFFERS (NUM_BUFFERS)
    ) u_vc_allocator (
        .CLK    (CLK),
        .nRST   (nRST),
        .buf_if (buf_if.vcalloc)
    );

    switch_allocator #(
        .NUM_BUFFERS (NUM_BUFFERS)
    ) u_switch_allocator (
        .CLK       (CLK),
        .nRST      (nRST),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_vc    (out_vc),
        .out_flit  (out_flit),
        .buf_if    (buf_if.switch)
    );

endmodule

// ==== rtl/switch_allocator.sv ====
`timescale 1ns/1ps

module switch_allocator #(
    parameter int NUM_BUFFERS = 2
) (
    input  logic                              CLK,
    input  logic                              nRST,
    input  logic [noc_pkg::NUM_OUTPORTS-1:0]  out_ready,
    output logic [noc_pkg::NUM_OUTPORTS-1:0]  out_valid,
    output logic                              out_vc,
    output noc_pkg::flit_t                    out_flit,
    buffers_if.switch                         buf_if
);
    localparam int IW = $clog2(NUM_BUFFERS);

    logic [NUM_BUFFERS-1:0] eligible;
    logic [IW-1:0]          rr_ptr;
    logic [IW-1:0]          sel;
    logic                   found;

    always_comb begin
        int idx;
        for (int i = 0; i < NUM_BUFFERS; i++) begin
            eligible[i] = buf_if.req_switch[i] && !buf_if.empty[i]
                          && out_ready[buf_if.outport_sel[i]];
        end
        found = 1'b0;
        sel   = rr_ptr;
        for (int k = 0; k < NUM_BUFFERS; k++) begin
            idx = (int'(rr_ptr) + k) % NUM_BUFFERS;
            if (!found && eligible[idx]) begin
                found = 1'b1;
                sel   = IW'(idx);
            end
        end
        buf_if.REN      = '0;
        buf_if.REN[sel] = found;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            out_valid <= '0;
            rr_ptr    <= '0;
        end else begin
            out_valid <= '0;
            if (found) begin
                out_valid[buf_if.outport_sel[sel]] <= 1'b1;
                rr_ptr <= (sel == IW'(NUM_BUFFERS - 1)) ? '0 : sel + 1'b1;
            end
        end
    end

    // the flit leaves one cycle after its read.
    always_ff @(posedge CLK) begin
        if (found) begin
            out_flit <= buf_if.rdata[sel];
            out_vc   <= buf_if.vc_sel[sel];
        end
    end

    assert property (@(posedge CLK) disable iff (!nRST) $onehot0(buf_if.REN))
        else $error("switch_allocator: more than one buffer read in a cycle");

endmodule

// ==== rtl/vc_allocator.sv ====
`timescale 1ns/1ps

module vc_allocator #(
    parameter int NUM_BUFFERS = 2
) (
    input logic        CLK,
    input logic        nRST,
    buffers_if.vcalloc buf_if
);
    localparam int IW = $clog2(NUM_BUFFERS);

    logic [noc_pkg::NUM_OUTPORTS-1:0][1:0] busy;
    logic [NUM_BUFFERS-1:0]                eligible;
    logic [IW-1:0]                         rr_ptr;
    logic [IW-1:0]                         sel;
    logic                                  found;
    noc_pkg::port_t                        sel_port;

    always_comb begin
        int idx;
        // a request only competes when its port still has a free channel.
        for (int i = 0; i < NUM_BUFFERS; i++) begin
            eligible[i] = buf_if.req_vc[i] && (busy[buf_if.outport_sel[i]] != 2'b11);
        end
        found = 1'b0;
        sel   = rr_ptr;
        for (int k = 0; k < NUM_BUFFERS; k++) begin
            idx = (int'(rr_ptr) + k) % NUM_BUFFERS;
            if (!found && eligible[idx]) begin
                found = 1'b1;
                sel   = IW'(idx);
            end
        end
        sel_port                = buf_if.outport_sel[sel];
        buf_if.vc_granted       = '0;
        buf_if.vc_granted[sel]  = found;
        buf_if.vc_selection     = busy[sel_port][0];
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy   <= '0;
            rr_ptr <= '0;
        end else begin
            for (int i = 0; i < NUM_BUFFERS; i++) begin
                if (buf_if.pkt_release[i]) begin
                    busy[buf_if.outport_sel[i]][buf_if.vc_sel[i]] <= 1'b0;
                end
            end
            if (found) begin
                busy[sel_port][buf_if.vc_selection] <= 1'b1;
                rr_ptr <= (sel == IW'(NUM_BUFFERS - 1)) ? '0 : sel + 1'b1;
            end
        end
    end

    for (genvar i = 0; i < NUM_BUFFERS; i++) begin : g_release_chk
        assert property (@(posedge CLK) disable iff (!nRST)
            buf_if.pkt_release[i] |-> busy[buf_if.outport_sel[i]][buf_if.vc_sel[i]])
            else $error("vc_allocator: buffer %0d released a channel that is not busy", i);
    end

endmodule

// ==== tests/router_tb_model.svh ====
`ifndef ROUTER_TB_MODEL_SVH
`define ROUTER_TB_MODEL_SVH

logic [31:0]        lfsr_state = 32'hf509;

// flits still to be written, and flits still to be seen at the output, per input VC.
noc_pkg::flit_t     send_q [NUM_VCS][$];
noc_pkg::flit_t     exp_q [NUM_VCS][$];

logic [NUM_VCS-1:0] open_pkt;
int                 cur_port [NUM_VCS];
logic               cur_vc [NUM_VCS];
int                 remaining [NUM_VCS];
int                 total_flits;
int                 flits_seen;
int                 flit_errors;
int                 port_errors;
int                 vc_errors;
int                 other_errors;

// fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit taken.
function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int k = 0; k < n; k++) begin
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        value = {value[30:0], fb};
    end
    return value;
endfunction

function automatic int flit_count(input logic [7:0] len);
    return (len == 8'd0) ? 1 : int'(len);
endfunction

function automatic noc_pkg::port_t expected_port(input noc_pkg::head_fields_t hdr);
    if (int'(hdr.dest_x) > ROUTER_X) return noc_pkg::PORT_EAST;
    if (int'(hdr.dest_x) < ROUTER_X) return noc_pkg::PORT_WEST;
    if (int'(hdr.dest_y) > ROUTER_Y) return noc_pkg::PORT_NORTH;
    if (int'(hdr.dest_y) < ROUTER_Y) return noc_pkg::PORT_SOUTH;
    return noc_pkg::PORT_LOCAL;
endfunction

task automatic check_flit(input noc_pkg::flit_t got, input noc_pkg::flit_t exp);
    if (got !== exp) begin
        $display("ERROR at %0t: flit got %h expected %h", $time, got, exp);
        flit_errors++;
    end
endtask

task automatic check_port(input noc_pkg::port_t got, input noc_pkg::port_t exp);
    if (got !== exp) begin
        $display("ERROR at %0t: port got %s expected %s", $time, got.name(), exp.name());
        port_errors++;
    end
endtask

task automatic check_vc(input logic got, input logic exp);
    if (got !== exp) begin
        $display("ERROR at %0t: out_vc got %b expected %b", $time, got, exp);
        vc_errors++;
    end
endtask

`endif

// ==== tests/router_tb.sv ====
`timescale 1ns/1ps

module router_tb;

    localparam int NUM_VCS = 3;
    localparam int VC_W = $clog2(NUM_VCS);
    localparam int DEPTH = 4;
    localparam int ROUTER_X = 1;
    localparam int ROUTER_Y = 1;
    localparam int NUM_PKTS = 60;
    localparam int MAX_CYCLES = 20000;
    // the first packets go local, east, west, north and south.
    localparam int DIR_X [5] = '{1, 3, 0, 1, 1};
    localparam int DIR_Y [5] = '{1, 0, 2, 3, 0};

    logic                             CLK;
    logic                             nRST;
    logic                             in_valid;
    logic [VC_W-1:0]                  in_vc;
    noc_pkg::flit_t                   in_flit;
    logic [NUM_VCS-1:0]               buf_full;
    logic [noc_pkg::NUM_OUTPORTS-1:0] out_ready;
    logic [noc_pkg::NUM_OUTPORTS-1:0] out_valid;
    logic                             out_vc;
    noc_pkg::flit_t                   out_flit;
    int                               cycles;

    `include "router_tb_model.svh"

    router_input_port #(
        .NUM_BUFFERS (NUM_VCS),
        .DEPTH       (DEPTH),
        .ROUTER_X    (ROUTER_X),
        .ROUTER_Y    (ROUTER_Y)
    ) UUT (
        .CLK       (CLK),
        .nRST      (nRST),
        .in_valid  (in_valid),
        .in_vc     (in_vc),
        .in_flit   (in_flit),
        .buf_full  (buf_full),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_vc    (out_vc),
        .out_flit  (out_flit)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    task automatic build_packets();
        noc_pkg::head_fields_t hdr;
        noc_pkg::flit_t        flit;
        int                    vc;
        int                    n_flits;
        for (int n = 0; n < NUM_PKTS; n++) begin
            vc = int'(lfsr_bits(8) % NUM_VCS);
            hdr.dest_x = 4'(lfsr_bits(2));
            hdr.dest_y = 4'(lfsr_bits(2));
            hdr.length = 8'(lfsr_bits(3) % 7);
            hdr.tag = 16'h0100 + 16'(n);
            if (n < 5) begin
                hdr.dest_x = 4'(DIR_X[n]);
                hdr.dest_y = 4'(DIR_Y[n]);
            end
            if (n < 2) begin
                hdr.length = 8'(n);
            end
            flit.head = 1'b1;
            flit.payload.head = hdr;
            send_q[vc].push_back(flit);
            exp_q[vc].push_back(flit);
            n_flits = flit_count(hdr.length);
            total_flits += n_flits;
            for (int b = 1; b < n_flits; b++) begin
                flit.head = 1'b0;
                flit.payload.data = lfsr_bits(32);
                send_q[vc].push_back(flit);
                exp_q[vc].push_back(flit);
            end
        end
    endtask

    task automatic drive_inputs();
        int vc;
        for (int p = 0; p < noc_pkg::NUM_OUTPORTS; p++) begin
            out_ready[p] = (lfsr_bits(2) != 0);
        end
        vc = int'(lfsr_bits(8) % NUM_VCS);
        in_valid = 1'b0;
        if (lfsr_bits(2) != 0 && send_q[vc].size() > 0 && !buf_full[vc]) begin
            in_valid = 1'b1;
            in_vc = VC_W'(vc);
            in_flit = send_q[vc].pop_front();
        end
    endtask

    task automatic accept_head(input int port);
        int src;
        src = -1;
        for (int i = 0; i < NUM_VCS; i++) begin
            if (exp_q[i].size() > 0 && exp_q[i][0].head
                && exp_q[i][0].payload.head.tag == out_flit.payload.head.tag) begin
                src = i;
            end
        end
        if (src < 0) begin
            $display("ERROR at %0t: head with tag %h matches no waiting packet",
                     $time, out_flit.payload.head.tag);
            other_errors++;
        end else begin
            check_port(noc_pkg::port_t'(port), expected_port(exp_q[src][0].payload.head));
            for (int i = 0; i < NUM_VCS; i++) begin
                if (open_pkt[i] && cur_port[i] == port && cur_vc[i] == out_vc) begin
                    $display("ERROR at %0t: port %0d vc %0d carries two packets at once",
                             $time, port, out_vc);
                    other_errors++;
                end
            end
            remaining[src] = flit_count(exp_q[src][0].payload.head.length) - 1;
            open_pkt[src] = (remaining[src] > 0);
            cur_port[src] = port;
            cur_vc[src] = out_vc;
            check_flit(out_flit, exp_q[src].pop_front());
            flits_seen++;
        end
    endtask

    task automatic accept_body(input int port);
        int src;
        src = -1;
        for (int i = 0; i < NUM_VCS; i++) begin
            if (open_pkt[i] && cur_port[i] == port && exp_q[i][0] == out_flit) begin
                src = i;
            end
        end
        if (src < 0) begin
            for (int i = 0; i < NUM_VCS; i++) begin
                if (open_pkt[i] && cur_port[i] == port && cur_vc[i] == out_vc) begin
                    src = i;
                end
            end
        end
        if (src < 0) begin
            $display("ERROR at %0t: body flit on port %0d vc %0d belongs to no open packet",
                     $time, port, out_vc);
            other_errors++;
        end else begin
            check_vc(out_vc, cur_vc[src]);
            check_flit(out_flit, exp_q[src].pop_front());
            flits_seen++;
            remaining[src]--;
            open_pkt[src] = (remaining[src] > 0);
        end
    endtask

    // out_ready still holds the level of the cycle that led to this out_valid.
    task automatic monitor_outputs();
        int port;
        if ((out_valid & ~out_ready) != '0) begin
            $display("ERROR at %0t: out_valid %b after a cycle with out_ready %b",
                     $time, out_valid, out_ready);
            other_errors++;
        end
        if (!$onehot0(out_valid)) begin
            $display("ERROR at %0t: out_valid %b is not one-hot", $time, out_valid);
            other_errors++;
        end else if (out_valid != '0) begin
            port = 0;
            for (int p = 0; p < noc_pkg::NUM_OUTPORTS; p++) begin
                if (out_valid[p]) begin
                    port = p;
                end
            end
            if (out_flit.head) begin
                accept_head(port);
            end else begin
                accept_body(port);
            end
        end
    endtask

    initial begin
        nRST = 1'b0;
        in_valid = 1'b0;
        in_vc = '0;
        in_flit = '0;
        out_ready = '1;
        open_pkt = '0;
        total_flits = 0;
        flits_seen = 0;
        flit_errors = 0;
        port_errors = 0;
        vc_errors = 0;
        other_errors = 0;
        build_packets();
        repeat (3) @(negedge CLK);
        nRST = 1'b1;

        repeat (8) begin
            @(negedge CLK);
            if (out_valid !== '0 || buf_full !== '0) begin
                $display("ERROR at %0t: out_valid %b or buf_full %b high before any write",
                         $time, out_valid, buf_full);
                other_errors++;
            end
        end

        cycles = 0;
        while (flits_seen < total_flits && cycles < MAX_CYCLES) begin
            @(negedge CLK);
            monitor_outputs();
            drive_inputs();
            cycles++;
        end
        if (flits_seen < total_flits) begin
            $display("timeout: only %0d of %0d flits left the router in %0d cycles",
                     flits_seen, total_flits, MAX_CYCLES);
            other_errors++;
        end

        // any flit after the last expected one is a duplicate.
        in_valid = 1'b0;
        out_ready = '1;
        repeat (20) begin
            @(negedge CLK);
            monitor_outputs();
        end

        $display("errors: flit=%0d port=%0d vc=%0d other=%0d",
                 flit_errors, port_errors, vc_errors, other_errors);
        if (flit_errors + port_errors + vc_errors + other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+tests
rtl/noc_pkg.sv
rtl/buffers_if.sv
rtl/flit_fifo.sv
rtl/flit_counter.sv
rtl/buffers.sv
rtl/route_compute.sv
rtl/vc_allocator.sv
rtl/switch_allocator.sv
rtl/router_input_port.sv
tests/router_tb.sv
